/* hw/cmd_xclk_pkg.sv */
`default_nettype none

package cmd_xclk_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CMD_WIDTH      = 32;                   // host command word
    localparam int REG_WIDTH      = 16;                   // register and result value
    localparam int REG_COUNT      = 4;                    // size of the register file
    localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);
    localparam int TAG_WIDTH      = 8;                    // sequence tag, wraps at 256
    localparam int OPCODE_WIDTH   = 4;
    localparam int RSVD_WIDTH     = CMD_WIDTH - OPCODE_WIDTH - 2 * REG_ADDR_WIDTH - REG_WIDTH;

    // opcodes, anything above OP_SUM is illegal
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP  = 4'h0,
        OP_LOAD = 4'h1,   // dst = imm
        OP_ADDI = 4'h2,   // dst = dst + imm
        OP_XOR  = 4'h3,   // dst = dst ^ src
        OP_READ = 4'h4,   // emit dst
        OP_SUM  = 4'h5    // emit dst + src, no write back
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // structs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raw word as written by the host; opcode kept raw so bad codes survive
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;   // 31:28
        logic [REG_ADDR_WIDTH-1:0] dst;      // 27:26
        logic [REG_ADDR_WIDTH-1:0] src;      // 25:24
        logic [RSVD_WIDTH-1:0]     rsvd;     // 23:16
        logic [REG_WIDTH-1:0]      imm;      // 15:0
    } cmd_word_t;

    typedef struct packed {
        opcode_e                   opcode;   // forced to OP_NOP when illegal
        logic                      illegal;
        logic [REG_ADDR_WIDTH-1:0] dst;
        logic [REG_ADDR_WIDTH-1:0] src;
        logic [REG_WIDTH-1:0]      imm;
    } dec_cmd_t;

    typedef struct packed {
        logic [REG_WIDTH-1:0] value;
        logic                 err;
    } exec_res_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [REG_WIDTH-1:0] value;
        logic                 err;
    } result_t;

endpackage

`default_nettype wire

/* hw/asynchronous_buffer.sv */
`default_nettype none

module asynchronous_buffer #(
    parameter int BUFFER_DEPTH = 16                        // power of two, 4 or more
) (
    input  wire logic                             write_clk_i,
    input  wire logic                             write_rstn_i,
    input  wire logic                             read_clk_i,
    input  wire logic                             read_rstn_i,
    input  wire logic                             write_i,       // write strobe
    input  wire logic                             read_i,        // pop strobe
    output logic                                  empty_o,       // read domain
    output logic                                  full_o,        // write domain
    input  wire logic [cmd_xclk_pkg::CMD_WIDTH-1:0] write_data_i,
    output logic      [cmd_xclk_pkg::CMD_WIDTH-1:0] read_data_o
);
    import cmd_xclk_pkg::*;

    localparam int PTR_SIZE = $clog2(BUFFER_DEPTH);

    // full needs two gray msbs below the wrap bit, so depth below 4 cannot work
    if (BUFFER_DEPTH < 4 || (BUFFER_DEPTH & (BUFFER_DEPTH - 1)) != 0) begin : g_depth_check
        $error("BUFFER_DEPTH must be a power of two of 4 or more");
    end

    logic [CMD_WIDTH-1:0] buffer_mem [BUFFER_DEPTH];

    logic [PTR_SIZE:0] write_ptr;                          // extra bit marks the wrap
    logic [PTR_SIZE:0] read_ptr;
    logic [PTR_SIZE:0] gray_write_ptr;
    logic [PTR_SIZE:0] gray_read_ptr;
    logic [1:0][PTR_SIZE:0] write_gray_sync;               // write ptr seen by reader
    logic [1:0][PTR_SIZE:0] read_gray_sync;                // read ptr seen by writer
    logic write_en;
    logic read_en;

    assign write_en = write_i & ~full_o;                   // writes while full are dropped
    assign read_en  = read_i & ~empty_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge write_clk_i) begin
        if (write_en) begin
            buffer_mem[write_ptr[PTR_SIZE-1:0]] <= write_data_i;
        end
    end

    // read data shows up one read clock after the pop
    always_ff @(posedge read_clk_i) begin
        if (read_en) begin
            read_data_o <= buffer_mem[read_ptr[PTR_SIZE-1:0]];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge write_clk_i or negedge write_rstn_i) begin
        if (!write_rstn_i) begin
            write_ptr <= '0;
        end else if (write_en) begin
            write_ptr <= write_ptr + 1'b1;
        end
    end

    always_ff @(posedge read_clk_i or negedge read_rstn_i) begin
        if (!read_rstn_i) begin
            read_ptr <= '0;
        end else if (read_en) begin
            read_ptr <= read_ptr + 1'b1;
        end
    end

    assign gray_write_ptr = (write_ptr >> 1) ^ write_ptr;  // one bit flips per step
    assign gray_read_ptr  = (read_ptr >> 1) ^ read_ptr;

    // two flop synchronizers, one into each opposite domain
    always_ff @(posedge read_clk_i or negedge read_rstn_i) begin
        if (!read_rstn_i) begin
            write_gray_sync <= '0;
        end else begin
            write_gray_sync <= {write_gray_sync[0], gray_write_ptr};
        end
    end

    always_ff @(posedge write_clk_i or negedge write_rstn_i) begin
        if (!write_rstn_i) begin
            read_gray_sync <= '0;
        end else begin
            read_gray_sync <= {read_gray_sync[0], gray_read_ptr};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // full when writer is one lap ahead, in gray that is the top two bits inverted
    assign full_o  = gray_write_ptr == {~read_gray_sync[1][PTR_SIZE:PTR_SIZE-1],
                                        read_gray_sync[1][PTR_SIZE-2:0]};
    assign empty_o = gray_read_ptr == write_gray_sync[1];

    // dropped writes must leave the pointer alone for the next write clock
    a_no_write_when_full: assert property (
        @(posedge write_clk_i) disable iff (!write_rstn_i)
        (write_i && full_o) |=> $stable(write_ptr)
    );

    a_no_read_when_empty: assert property (
        @(posedge read_clk_i) disable iff (!read_rstn_i)
        (read_i && empty_o) |=> $stable(read_ptr)
    );

endmodule

`default_nettype wire

/* hw/cmd_decode.sv */
`default_nettype none

module cmd_decode (
    input  wire logic                     read_clk_i,
    input  wire logic                     read_rstn_i,
    input  wire logic                     fifo_empty_i,
    input  wire logic                     pause_i,      // consumer hold, stops popping
    input  wire cmd_xclk_pkg::cmd_word_t  fifo_data_i,  // valid the cycle after a pop
    output logic                          fifo_pop_o,
    output logic                          dec_valid_o,
    output cmd_xclk_pkg::dec_cmd_t        dec_cmd_o
);
    import cmd_xclk_pkg::*;

    logic     data_present_q;   // fifo_data_i holds a fresh word this cycle
    logic     illegal;
    dec_cmd_t dec_d;

    // pop whenever something is there and nobody asked us to wait
    assign fifo_pop_o = ~fifo_empty_i & ~pause_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign illegal = !(fifo_data_i.opcode inside {OP_NOP, OP_LOAD, OP_ADDI,
                                                  OP_XOR, OP_READ, OP_SUM});

    always_comb begin
        dec_d.illegal = illegal;
        // bad codes travel as NOP plus the flag, execute never sees a stray code
        dec_d.opcode  = illegal ? OP_NOP : opcode_e'(fifo_data_i.opcode);
        dec_d.dst     = fifo_data_i.dst;
        dec_d.src     = fifo_data_i.src;
        dec_d.imm     = fifo_data_i.imm;  // reserved bits are ignored
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge read_clk_i or negedge read_rstn_i) begin
        if (!read_rstn_i) begin
            data_present_q <= 1'b0;
            dec_valid_o    <= 1'b0;
        end else begin
            data_present_q <= fifo_pop_o;      // buffer data lands next cycle
            dec_valid_o    <= data_present_q;  // two cycles after the pop
        end
    end

    // payload only, qualified by dec_valid_o
    always_ff @(posedge read_clk_i) begin
        if (data_present_q) begin
            dec_cmd_o <= dec_d;
        end
    end

    // popping an empty buffer would hand stale data down the pipe
    a_no_pop_when_empty: assert property (
        @(posedge read_clk_i) disable iff (!read_rstn_i)
        fifo_empty_i |-> !fifo_pop_o
    );

endmodule

`default_nettype wire

/* hw/cmd_execute.sv */
`default_nettype none

module cmd_execute (
    input  wire logic                    read_clk_i,
    input  wire logic                    read_rstn_i,
    input  wire logic                    dec_valid_i,
    input  wire cmd_xclk_pkg::dec_cmd_t  dec_cmd_i,
    output logic                         exec_valid_o,  // only READ, SUM and illegal
    output cmd_xclk_pkg::exec_res_t      exec_res_o
);
    import cmd_xclk_pkg::*;

    logic [REG_WIDTH-1:0] regs [REG_COUNT];   // register file
    logic [REG_WIDTH-1:0] dst_val;
    logic [REG_WIDTH-1:0] src_val;
    logic                 wr_en;
    logic [REG_WIDTH-1:0] wr_data;
    logic                 res_valid;
    exec_res_t            res_d;

    assign dst_val = regs[dec_cmd_i.dst];
    assign src_val = regs[dec_cmd_i.src];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation unit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_en     = 1'b0;
        wr_data   = dst_val;
        res_valid = 1'b0;
        res_d     = '0;
        if (dec_valid_i) begin
            if (dec_cmd_i.illegal) begin
                res_valid = 1'b1;  // flagged result, value stays 0
                res_d.err = 1'b1;
            end else begin
                case (dec_cmd_i.opcode)
                    OP_LOAD: begin
                        wr_en   = 1'b1;
                        wr_data = dec_cmd_i.imm;
                    end
                    OP_ADDI: begin
                        wr_en   = 1'b1;
                        wr_data = dst_val + dec_cmd_i.imm;  // wraps mod 2^16
                    end
                    OP_XOR: begin
                        wr_en   = 1'b1;
                        wr_data = dst_val ^ src_val;
                    end
                    OP_READ: begin
                        res_valid   = 1'b1;
                        res_d.value = dst_val;
                    end
                    OP_SUM: begin
                        res_valid   = 1'b1;
                        res_d.value = dst_val + src_val;    // no write back
                    end
                    default: ;                              // NOP
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reads and the write back share this stage, so program order holds
    always_ff @(posedge read_clk_i or negedge read_rstn_i) begin
        if (!read_rstn_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            exec_valid_o <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[dec_cmd_i.dst] <= wr_data;
            end
            exec_valid_o <= res_valid;
        end
    end

    always_ff @(posedge read_clk_i) begin
        if (res_valid) begin
            exec_res_o <= res_d;
        end
    end

    // decode must always hand over a known opcode with its valid
    a_opcode_known: assert property (
        @(posedge read_clk_i) disable iff (!read_rstn_i)
        dec_valid_i |-> !$isunknown(dec_cmd_i.opcode)
    );

endmodule

`default_nettype wire

/* hw/cmd_result.sv */
`default_nettype none

module cmd_result (
    input  wire logic                     read_clk_i,
    input  wire logic                     read_rstn_i,
    input  wire logic                     exec_valid_i,
    input  wire cmd_xclk_pkg::exec_res_t  exec_res_i,
    output logic                          result_valid_o,  // one cycle per result
    output cmd_xclk_pkg::result_t         result_o         // held between pulses
);
    import cmd_xclk_pkg::*;

    logic [TAG_WIDTH-1:0] tag_q;   // next tag to hand out

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tag counter and strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge read_clk_i or negedge read_rstn_i) begin
        if (!read_rstn_i) begin
            tag_q          <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= exec_valid_i;
            if (exec_valid_i) begin
                tag_q <= tag_q + 1'b1;  // wraps after 255
            end
        end
    end

    // output register, only loads on a new result
    always_ff @(posedge read_clk_i) begin
        if (exec_valid_i) begin
            result_o.tag   <= tag_q;
            result_o.value <= exec_res_i.value;
            result_o.err   <= exec_res_i.err;
        end
    end

    // consumer samples this as a plain strobe with no handshake
    a_valid_known: assert property (
        @(posedge read_clk_i) disable iff (!read_rstn_i)
        !$isunknown(result_valid_o)
    );

endmodule

`default_nettype wire

/* hw/cmd_xclk_top.sv */
`default_nettype none

module cmd_xclk_top #(
    parameter int FIFO_DEPTH = 16            // entries in the crossing buffer
) (
    // write domain
    input  wire logic                     write_clk_i,
    input  wire logic                     write_rstn_i,
    input  wire logic                     cmd_write_i,
    input  wire cmd_xclk_pkg::cmd_word_t  cmd_word_i,
    output logic                          cmd_full_o,     // writes now are dropped
    // read domain
    input  wire logic                     read_clk_i,
    input  wire logic                     read_rstn_i,
    input  wire logic                     pause_i,
    output logic                          result_valid_o,
    output cmd_xclk_pkg::result_t         result_o
);
    import cmd_xclk_pkg::*;

    logic [CMD_WIDTH-1:0] cmd_flat;      // buffer port is a plain vector
    logic [CMD_WIDTH-1:0] fifo_rdata;
    cmd_word_t            fifo_word;
    logic                 fifo_empty;
    logic                 fifo_pop;
    logic                 dec_valid;
    dec_cmd_t             dec_cmd;
    logic                 exec_valid;
    exec_res_t            exec_res;

    assign cmd_flat  = cmd_word_i;
    assign fifo_word = cmd_word_t'(fifo_rdata);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock crossing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    asynchronous_buffer #(
        .BUFFER_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .write_clk_i  (write_clk_i),
        .write_rstn_i (write_rstn_i),
        .read_clk_i   (read_clk_i),
        .read_rstn_i  (read_rstn_i),
        .write_i      (cmd_write_i),
        .read_i       (fifo_pop),
        .empty_o      (fifo_empty),
        .full_o       (cmd_full_o),
        .write_data_i (cmd_flat),
        .read_data_o  (fifo_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side pipeline, decode then execute then result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cmd_decode u_decode (
        .read_clk_i   (read_clk_i),
        .read_rstn_i  (read_rstn_i),
        .fifo_empty_i (fifo_empty),
        .pause_i      (pause_i),
        .fifo_data_i  (fifo_word),
        .fifo_pop_o   (fifo_pop),
        .dec_valid_o  (dec_valid),
        .dec_cmd_o    (dec_cmd)
    );

    cmd_execute u_execute (
        .read_clk_i   (read_clk_i),
        .read_rstn_i  (read_rstn_i),
        .dec_valid_i  (dec_valid),
        .dec_cmd_i    (dec_cmd),
        .exec_valid_o (exec_valid),
        .exec_res_o   (exec_res)
    );

    cmd_result u_result (
        .read_clk_i     (read_clk_i),
        .read_rstn_i    (read_rstn_i),
        .exec_valid_i   (exec_valid),
        .exec_res_i     (exec_res),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

/* dv/cmd_xclk_tb.sv */
`default_nettype none

module cmd_xclk_tb;
    import cmd_xclk_pkg::*;

    localparam int          FIFO_DEPTH      = 8;
    localparam int          READ_PERIOD     = 10;
    localparam int          WRITE_PERIOD    = 14;
    localparam int          PAUSE_TEST_TIME = 3000;   // fill, drop and drain of the full test
    localparam int unsigned SEED            = 32'h809393dd;
    localparam string       VECTOR_FILE     = "dv/cmd_xclk_vectors.txt";

    logic      write_clk_i;
    logic      write_rstn_i;
    logic      read_clk_i;
    logic      read_rstn_i;
    logic      cmd_write_i;
    cmd_word_t cmd_word_i;
    logic      cmd_full_o;
    logic      pause_i;
    logic      result_valid_o;
    result_t   result_o;

    result_t              exp_q[$];                  // expected results, command order
    cmd_word_t            cmd_q[$];                  // words still to write
    logic [REG_WIDTH-1:0] model_regs [REG_COUNT];    // register state by the opcode rules
    logic [TAG_WIDTH-1:0] next_tag       = '0;
    int                   record_count   = 0;
    int                   expected_count = 0;
    int                   result_count   = 0;
    bit                   vectors_loaded = 1'b0;
    result_t              last_result;               // result_o must hold this between pulses
    bit                   result_seen    = 1'b0;

    cmd_xclk_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .write_clk_i    (write_clk_i),
        .write_rstn_i   (write_rstn_i),
        .cmd_write_i    (cmd_write_i),
        .cmd_word_i     (cmd_word_i),
        .cmd_full_o     (cmd_full_o),
        .read_clk_i     (read_clk_i),
        .read_rstn_i    (read_rstn_i),
        .pause_i        (pause_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clocks and resets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        read_clk_i = 1'b0;
        forever #(READ_PERIOD / 2) read_clk_i = ~read_clk_i;
    end

    initial begin
        write_clk_i = 1'b0;
        forever #(WRITE_PERIOD / 2) write_clk_i = ~write_clk_i;   // unrelated to read clock
    end

    initial begin
        read_rstn_i = 1'b0;
        repeat (2) @(posedge read_clk_i);
        #1 read_rstn_i = 1'b1;
    end

    initial begin
        write_rstn_i = 1'b0;
        repeat (2) @(posedge write_clk_i);
        #1 write_rstn_i = 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, expected %h, got %h", $time, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // only the write operations move register state, results come from the vectors
    function automatic void update_model(input cmd_word_t cmd);
        case (cmd.opcode)
            OP_LOAD: model_regs[cmd.dst] = cmd.imm;
            OP_ADDI: model_regs[cmd.dst] = model_regs[cmd.dst] + cmd.imm;   // mod 2^16
            OP_XOR:  model_regs[cmd.dst] = model_regs[cmd.dst] ^ model_regs[cmd.src];
            default: ;
        endcase
    endfunction

    task automatic load_vectors();
        int          fd;
        int          bad_lines;
        string       line;
        logic [31:0] word;
        logic [31:0] tag;
        logic [31:0] value;
        logic [31:0] err;
        result_t     exp;
        bad_lines = 0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;                      // matches register reset
        end
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s, there is no stimulus to run", VECTOR_FILE);
            $display("*** TEST FAILED ***");
            $fatal(1, "vector file missing");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 0) begin
                    case (line[0])
                        "C": begin
                            if ($sscanf(line, "C %h", word) == 1) begin
                                cmd_q.push_back(word);
                                update_model(word);
                                record_count++;
                            end else begin
                                bad_lines++;
                            end
                        end
                        "R": begin
                            if ($sscanf(line, "R %h %h %h", tag, value, err) == 3) begin
                                exp.tag   = tag[TAG_WIDTH-1:0];
                                exp.value = value[REG_WIDTH-1:0];
                                exp.err   = err[0];
                                exp_q.push_back(exp);
                                next_tag++;                  // full test continues from here
                                expected_count++;
                                record_count++;
                            end else begin
                                bad_lines++;
                            end
                        end
                        "#", "\n", "\r", " ": ;              // comment or blank
                        default: bad_lines++;
                    endcase
                end
            end
            $fclose(fd);
            if (bad_lines != 0 || record_count == 0) begin
                $display("%s has %0d lines that are neither a command nor a result",
                         VECTOR_FILE, bad_lines);
                $display("*** TEST FAILED ***");
                $fatal(1, "bad vector file");
            end else begin
                vectors_loaded = 1'b1;
            end
        end
    endtask

    // called at write edge + 1, returns there one write cycle after the strobe
    task automatic write_cmd(input cmd_word_t word);
        while (cmd_full_o) begin
            @(posedge write_clk_i);
            #1;
        end
        cmd_write_i = 1'b1;
        cmd_word_i  = word;
        @(posedge write_clk_i);
        #1;
        cmd_write_i = 1'b0;
    endtask

    task automatic wait_for_results();
        while (exp_q.size() != 0) begin
            @(posedge read_clk_i);
        end
        repeat (20) @(posedge read_clk_i);            // drains trailing commands, stray results
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // full and drop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_full_test();
        cmd_word_t word;
        result_t   exp;
        @(posedge read_clk_i);
        #1;
        pause_i = 1'b1;                               // reader stops popping, buffer fills
        @(posedge write_clk_i);
        #1;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            word        = '0;
            word.opcode = OP_READ;
            word.dst    = REG_ADDR_WIDTH'(i % REG_COUNT);
            cmd_write_i = 1'b1;                       // back to back, full is not watched
            cmd_word_i  = word;
            exp.tag     = next_tag;
            exp.value   = model_regs[word.dst];
            exp.err     = 1'b0;
            exp_q.push_back(exp);
            next_tag++;
            expected_count++;
            @(posedge write_clk_i);
            #1;
        end
        check_value(cmd_full_o, 1'b1, "full flag after eighth write");
        word        = '0;
        word.opcode = OP_READ;
        word.dst    = 2'd3;
        word.imm    = 16'hdead;
        cmd_word_i  = word;                           // ninth word, strobe still high
        @(posedge write_clk_i);
        #1;
        cmd_write_i = 1'b0;
        cmd_word_i  = '0;
        repeat (4) begin
            @(posedge write_clk_i);
            #1;
        end
        check_value(cmd_full_o, 1'b1, "full flag before releasing pause");
        @(posedge read_clk_i);
        #1;
        pause_i = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result checker, sampled mid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic take_result();
        result_t exp;
        if (exp_q.size() == 0) begin
            $display("result with tag %h arrived when none was expected", result_o.tag);
            $display("*** TEST FAILED ***");
            $fatal(1, "unexpected result");
        end else begin
            exp = exp_q.pop_front();
            check_value(result_o.tag, exp.tag, "result tag");
            check_value(result_o.value, exp.value, "result value");
            check_value(result_o.err, exp.err, "result err");
            result_count++;
        end
    endtask

    always @(negedge read_clk_i) begin
        if (read_rstn_i === 1'b1 && result_valid_o === 1'b1) begin
            take_result();
            last_result = result_o;
            result_seen = 1'b1;
        end else if (read_rstn_i === 1'b1 && result_seen) begin
            check_value(result_o, last_result, "result held between pulses");
        end
    end

    initial begin
        wait (vectors_loaded);
        #(record_count * 40 * READ_PERIOD + PAUSE_TEST_TIME);
        $display("timeout at %0t, results stopped arriving with %0d of %0d seen",
                 $time, result_count, expected_count);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int unsigned gap;
        void'($urandom(SEED));                        // one seed for the whole run
        cmd_write_i = 1'b0;
        cmd_word_i  = '0;
        pause_i     = 1'b0;
        load_vectors();
        wait (write_rstn_i && read_rstn_i);
        @(posedge write_clk_i);
        #1;
        foreach (cmd_q[i]) begin
            write_cmd(cmd_q[i]);
            gap = $urandom % 4;                       // idle write cycles, 0 to 3
            repeat (gap) begin
                @(posedge write_clk_i);
                #1;
            end
        end
        wait_for_results();
        run_full_test();
        wait_for_results();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cmd_xclk_vectors.txt */
# C <command word, hex>             opcode 31:28 dst 27:26 src 25:24 rsvd 23:16 imm 15:0
# R <tag, hex> <value, hex> <err>   next expected result, in order
C 10001234
C 40000000
R 00 1234 0
C 1400FFF0
C 24000025
C 44000000
R 01 0015 0
C 18000F0F
C 1C0000FF
C 3B000000
C 48000000
R 02 0FF0 0
C 59000000
R 03 1005 0
C 48000000
R 04 0FF0 0
C 1C00F000
C 5C000000
R 05 0234 0
C 7400ABCD
R 06 0000 1
C 44000000
R 07 0015 0
C F0001111
R 08 0000 1
C 0C5A9999
C 2C770100
C 4C000000
R 09 F100 0
C 30000000
C 40000000
R 0A 0000 0
C 2000FFFF
C 20000002
C 40000000
R 0B 0001 0
C 55000000
R 0C 002A 0
C 1400BEEF
C 36000000
C 44000000
R 0D B11F 0
C 5E000000
R 0E 00F0 0
C 4C000000
R 0F F100 0

/* cmd_xclk.f */
hw/cmd_xclk_pkg.sv
hw/asynchronous_buffer.sv
hw/cmd_decode.sv
hw/cmd_execute.sv
hw/cmd_result.sv
hw/cmd_xclk_top.sv
dv/cmd_xclk_tb.sv
